/* verilog/fpFmtPkg.sv */
/*
  Shared definitions for the floating-point format converter.
  Format codes follow the RISC-V fmt field, rounding modes follow the
  rm field. The width typedefs name the intermediate quantities that
  travel between the unpack and round stages.
*/

package fpFmtPkg;

  ////////////////////////////////////////
  // Format and rounding codes
  ////////////////////////////////////////

  // RISC-V fmt encoding
  typedef logic [1:0] fmtT;

  localparam fmtT fmtSingle = 2'b00;
  localparam fmtT fmtDouble = 2'b01;
  localparam fmtT fmtHalf   = 2'b10;
  localparam fmtT fmtRsvd   = 2'b11;

  // Static rounding modes; codes above rmm round as rne
  typedef enum logic [2:0] {
    rne = 3'b000,
    rtz = 3'b001,
    rdn = 3'b010,
    rup = 3'b011,
    rmm = 3'b100
  } rmT;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  // Register image, narrower values NaN-boxed
  typedef logic [63:0] fpWordT;
  // Unbiased exponent, covers double subnormals and overflow
  typedef logic signed [12:0] expT;
  // Significand, leading one at bit 52 once normalized
  typedef logic [52:0] sigT;
  // {invalid, overflow, underflow, inexact}
  typedef logic [3:0] flagsT;
  typedef logic [10:0] biasT;
  typedef logic [5:0] nfT;

  ////////////////////////////////////////
  // Per-format constants
  ////////////////////////////////////////

  localparam biasT sBias = 11'd127;
  localparam biasT dBias = 11'd1023;
  localparam biasT hBias = 11'd15;

  // Stored fraction bits, hidden one excluded
  localparam nfT sNf = 6'd23;
  localparam nfT dNf = 6'd52;
  localparam nfT hNf = 6'd10;

endpackage

/* verilog/fpCvtIf.sv */
/*
  Link between the unpack and round stages of the converter.
  One unpacked operand per cycle; valid qualifies every other field.
  The unpack stage drives it through producer, the round stage
  reads it through consumer.
*/

`timescale 1ns/1ns

interface fpCvtIf;

  logic               valid;
  logic               sign;
  fpFmtPkg::expT      exp;
  fpFmtPkg::sigT      sig;
  // Operand class, at most one set
  logic               isZero;
  logic               isInf;
  logic               isNaN;
  logic               isSnan;
  // Carried along for the round stage
  fpFmtPkg::fmtT      dstFmt;
  fpFmtPkg::rmT       rm;

  modport producer (output valid, sign, exp, sig, isZero, isInf, isNaN, isSnan, dstFmt, rm);
  modport consumer (input  valid, sign, exp, sig, isZero, isInf, isNaN, isSnan, dstFmt, rm);

endinterface

/* verilog/fmtParams.sv */
/*
  Exponent bias and fraction width for a format code.
  Purely combinational. With NumFmts of 2 only single and double
  exist, and half or reserved codes fall back to single values;
  the requesting stage is expected to flag such codes.
*/

`timescale 1ns/1ns

module fmtParams #(
  parameter int NumFmts = 3
) (
  input  fpFmtPkg::fmtT  fmt,
  output fpFmtPkg::biasT bias,
  output fpFmtPkg::nfT   nf
);

  always_comb begin
    case (fmt)
      fpFmtPkg::fmtDouble: begin
        bias = fpFmtPkg::dBias;
        nf   = fpFmtPkg::dNf;
      end
      fpFmtPkg::fmtHalf: begin
        // Half only exists in the three-format build
        bias = (NumFmts == 3) ? fpFmtPkg::hBias : fpFmtPkg::sBias;
        nf   = (NumFmts == 3) ? fpFmtPkg::hNf : fpFmtPkg::sNf;
      end
      fpFmtPkg::fmtSingle: begin
        bias = fpFmtPkg::sBias;
        nf   = fpFmtPkg::sNf;
      end
      default: begin
        // Reserved code
        bias = fpFmtPkg::sBias;
        nf   = fpFmtPkg::sNf;
      end
    endcase
  end

endmodule

/* verilog/fpUnpack.sv */
/*
  First converter stage. Pulls sign, exponent and fraction out of the
  source format, checks NaN-boxing, classifies the operand and
  normalizes subnormals. Output is registered onto the producer side
  of the stage link, one cycle after inValid.
*/

`timescale 1ns/1ns

module fpUnpack #(
  parameter int NumFmts = 3
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             inValid,
  input  fpFmtPkg::fmtT    srcFmt,
  input  fpFmtPkg::fmtT    dstFmt,
  input  fpFmtPkg::rmT     rm,
  input  fpFmtPkg::fpWordT operand,
  fpCvtIf.producer         out
);

  fpFmtPkg::biasT srcBias;
  fpFmtPkg::nfT   srcNf;
  logic           boxed;
  logic           sgn;
  logic [10:0]    expFld;
  logic [51:0]    fracR;
  logic [51:0]    fracL;
  logic           expZero;
  logic           expOnes;
  logic           fracZero;
  logic [5:0]     lzc;
  fpFmtPkg::expT  expN;
  fpFmtPkg::sigT  sigN;

  fmtParams #(.NumFmts(NumFmts)) srcParams (
    .fmt  (srcFmt),
    .bias (srcBias),
    .nf   (srcNf)
  );

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  // Fraction right-aligned here, exponent zero-extended
  always_comb begin
    boxed  = 1'b1;
    sgn    = operand[31];
    expFld = {3'b0, operand[30:23]};
    fracR  = {29'b0, operand[22:0]};
    case (srcFmt)
      fpFmtPkg::fmtDouble: begin
        sgn    = operand[63];
        expFld = operand[62:52];
        fracR  = operand[51:0];
      end
      fpFmtPkg::fmtHalf: begin
        boxed  = &operand[63:16];
        sgn    = operand[15];
        expFld = {6'b0, operand[14:10]};
        fracR  = {42'b0, operand[9:0]};
      end
      default: begin
        boxed  = &operand[63:32];
      end
    endcase
  end

  // Left-justify so the quiet bit always lands on bit 51
  assign fracL = fracR << (6'd52 - srcNf);

  // All-ones exponent field is 2*bias+1
  assign expOnes  = (expFld == {srcBias[9:0], 1'b1});
  assign expZero  = (expFld == 11'd0);
  assign fracZero = (fracR == 52'd0);

  ////////////////////////////////////////
  // Subnormal normalization
  ////////////////////////////////////////

  // Leading zeros of the justified fraction; last hit is the top one
  always_comb begin
    lzc = 6'd0;
    for (int i = 0; i < 52; i++) begin
      if (fracL[i]) lzc = 6'(51 - i);
    end
  end

  // Subnormal 0.f * 2^(1-bias) becomes 1.x * 2^(-bias-lzc)
  assign sigN = expZero ? ({fracL, 1'b0} << lzc) : {1'b1, fracL};
  assign expN = expZero ? (-fpFmtPkg::expT'(srcBias) - fpFmtPkg::expT'(lzc))
                        : (fpFmtPkg::expT'(expFld) - fpFmtPkg::expT'(srcBias));

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) out.valid <= 1'b0;
    else       out.valid <= inValid;
  end

  // A badly boxed operand reads as a quiet NaN, no invalid
  always_ff @(posedge clk) begin
    if (inValid) begin
      out.sign   <= sgn;
      out.exp    <= expN;
      out.sig    <= sigN;
      out.isZero <= boxed && expZero && fracZero;
      out.isInf  <= boxed && expOnes && fracZero;
      out.isNaN  <= !boxed || (expOnes && !fracZero);
      out.isSnan <= boxed && expOnes && !fracZero && !fracL[51];
      out.dstFmt <= dstFmt;
      out.rm     <= rm;
    end
  end

  // Both codes steer the round stage too, so bad ones break the whole pipe
  assert property (@(posedge clk) disable iff (!rstN)
    inValid |-> (srcFmt != fpFmtPkg::fmtRsvd) && (dstFmt != fpFmtPkg::fmtRsvd) &&
                (NumFmts == 3 || (srcFmt != fpFmtPkg::fmtHalf &&
                                  dstFmt != fpFmtPkg::fmtHalf)))
    else $error("fpUnpack: unsupported format code src=%0d dst=%0d", srcFmt, dstFmt);

endmodule

/* verilog/fpRound.sv */
/*
  Second converter stage. Rebiases to the destination format,
  denormalizes tiny values, rounds per rm, handles overflow and
  special operands, then packs and NaN-boxes the result.
  result and flags are registered one cycle after the link valid.
*/

`timescale 1ns/1ns

module fpRound #(
  parameter int NumFmts = 3
) (
  input  logic             clk,
  input  logic             rstN,
  fpCvtIf.consumer         in,
  output logic             outValid,
  output fpFmtPkg::fpWordT result,
  output fpFmtPkg::flagsT  flags
);

  fpFmtPkg::biasT   dstBias;
  fpFmtPkg::nfT     dstNf;
  fpFmtPkg::expT    be;
  fpFmtPkg::expT    dshWide;
  fpFmtPkg::expT    expRes;
  fpFmtPkg::expT    expMax;
  logic             denorm;
  logic [5:0]       dsh;
  logic [127:0]     wN;
  logic [127:0]     wD;
  logic             incN;
  logic             incD;
  logic [53:0]      rndN;
  logic [53:0]      rndD;
  logic             inexact;
  logic             tiny;
  logic             ovf;
  logic             toMax;
  logic [51:0]      fracMask;
  logic             sgnOut;
  logic [10:0]      expOut;
  logic [51:0]      fracOut;
  fpFmtPkg::fpWordT resNext;
  fpFmtPkg::flagsT  flagsNext;

  fmtParams #(.NumFmts(NumFmts)) dstParams (
    .fmt  (in.dstFmt),
    .bias (dstBias),
    .nf   (dstNf)
  );

  // Increment decision for one rounding position
  function automatic logic roundInc(input fpFmtPkg::rmT mode, input logic sgn,
                                    input logic lsb, input logic g, input logic s);
    case (mode)
      fpFmtPkg::rtz: roundInc = 1'b0;
      fpFmtPkg::rdn: roundInc = sgn & (g | s);
      fpFmtPkg::rup: roundInc = !sgn & (g | s);
      fpFmtPkg::rmm: roundInc = g;
      default:       roundInc = g & (s | lsb);
    endcase
  endfunction

  ////////////////////////////////////////
  // Rebias and alignment
  ////////////////////////////////////////

  assign be      = in.exp + fpFmtPkg::expT'(dstBias);
  assign denorm  = (be < 13'sd1);
  assign dshWide = 13'sd1 - be;
  // Past 63 only sticky remains
  assign dsh     = !denorm ? 6'd0 : (dshWide > 13'sd63) ? 6'd63 : dshWide[5:0];

  // Kept bits end at 75, guard is bit 74, sticky is everything below
  assign wN = {in.sig, 75'b0} >> (6'd52 - dstNf);
  assign wD = wN >> dsh;

  // Normal-precision rounding, used to decide tininess after rounding
  assign incN = roundInc(in.rm, in.sign, wN[75], wN[74], |wN[73:0]);
  assign rndN = {1'b0, wN[127:75]} + 54'(incN);

  // Actual rounding at the denormalized position
  assign incD    = roundInc(in.rm, in.sign, wD[75], wD[74], |wD[73:0]);
  assign rndD    = {1'b0, wD[127:75]} + 54'(incD);
  assign inexact = wD[74] | (|wD[73:0]);

  // Tiny unless a just-below-minimum value rounds up to the minimum normal
  assign tiny = denorm && !(be == 13'sd0 && rndN[dstNf + 6'd1]);

  // Subnormal may round into the smallest normal, normal may carry out
  assign expRes = denorm ? fpFmtPkg::expT'(rndD[dstNf])
                         : be + fpFmtPkg::expT'(rndD[dstNf + 6'd1]);

  assign expMax   = fpFmtPkg::expT'({dstBias[9:0], 1'b1});
  assign ovf      = !denorm && (expRes >= expMax);
  assign fracMask = ~({52{1'b1}} << dstNf);

  // Modes that stop at the largest finite value
  assign toMax = (in.rm == fpFmtPkg::rtz) || (in.rm == fpFmtPkg::rdn && !in.sign) ||
                 (in.rm == fpFmtPkg::rup && in.sign);

  ////////////////////////////////////////
  // Special cases and packing
  ////////////////////////////////////////

  always_comb begin
    sgnOut    = in.sign;
    expOut    = expRes[10:0];
    fracOut   = rndD[51:0] & fracMask;
    flagsNext = {2'b00, tiny & inexact, inexact};
    if (in.isNaN) begin
      // Canonical quiet NaN, only the top fraction bit set
      sgnOut    = 1'b0;
      expOut    = expMax[10:0];
      fracOut   = fracMask & ~(fracMask >> 1);
      flagsNext = {in.isSnan, 3'b000};
    end else if (in.isInf) begin
      expOut    = expMax[10:0];
      fracOut   = 52'd0;
      flagsNext = 4'b0000;
    end else if (in.isZero) begin
      expOut    = 11'd0;
      fracOut   = 52'd0;
      flagsNext = 4'b0000;
    end else if (ovf) begin
      expOut    = toMax ? {dstBias[9:0], 1'b0} : expMax[10:0];
      fracOut   = toMax ? fracMask : 52'd0;
      flagsNext = 4'b0101;
    end
  end

  // Narrow results get ones above them
  always_comb begin
    case (in.dstFmt)
      fpFmtPkg::fmtDouble: resNext = {sgnOut, expOut, fracOut};
      fpFmtPkg::fmtHalf:   resNext = {{48{1'b1}}, sgnOut, expOut[4:0], fracOut[9:0]};
      default:             resNext = {{32{1'b1}}, sgnOut, expOut[7:0], fracOut[22:0]};
    endcase
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) outValid <= 1'b0;
    else       outValid <= in.valid;
  end

  always_ff @(posedge clk) begin
    if (in.valid) begin
      result <= resNext;
      flags  <= flagsNext;
    end
  end

  // Every overflow is also inexact, whichever value it saturates to
  assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> (!flags[2] || flags[0]))
    else $error("fpRound: overflow without inexact, flags=%b", flags);

endmodule

/* verilog/fpCvt.sv */
/*
  Top level of the two-stage fcvt converter.
  inValid with its operand is sampled on a rising edge; outValid,
  result and flags follow exactly two cycles later. One operation
  may enter every cycle. NumFmts selects single/double (2) or adds
  half precision (3).
*/

`timescale 1ns/1ns

module fpCvt #(
  parameter int NumFmts = 3
) (
  input  logic             clk,
  input  logic             rstN,
  // Request side
  input  logic             inValid,
  input  fpFmtPkg::fmtT    srcFmt,
  input  fpFmtPkg::fmtT    dstFmt,
  input  fpFmtPkg::rmT     rm,
  input  fpFmtPkg::fpWordT operand,
  // Result side
  output logic             outValid,
  output fpFmtPkg::fpWordT result,
  output fpFmtPkg::flagsT  flags
);

  // Unpacked operand between the stages
  fpCvtIf cvtLink ();

  ////////////////////////////////////////
  // Stage 1, unpack and normalize
  ////////////////////////////////////////

  fpUnpack #(.NumFmts(NumFmts)) unpackStage (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .srcFmt  (srcFmt),
    .dstFmt  (dstFmt),
    .rm      (rm),
    .operand (operand),
    .out     (cvtLink.producer)
  );

  ////////////////////////////////////////
  // Stage 2, round and pack
  ////////////////////////////////////////

  fpRound #(.NumFmts(NumFmts)) roundStage (
    .clk      (clk),
    .rstN     (rstN),
    .in       (cvtLink.consumer),
    .outValid (outValid),
    .result   (result),
    .flags    (flags)
  );

endmodule

/* dv/fpCvtVectors.svh */
/*
  Conversion vectors for the fcvt converter testbench, worked out by
  hand from IEEE 754 rules. Included inside the testbench module after
  the row type has been declared.
*/

// Columns: srcFmt, dstFmt, rm, operand, expected result, expected flags {nv,of,uf,nx}
// Formats 0 single, 1 double, 2 half; rm 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm
localparam int NumRows = 29;

localparam vecRowT vecTable [NumRows] = '{
  // Exact widening, normals, zeros and infinities
  {2'd2, 2'd0, 3'd0, 64'hFFFFFFFFFFFF3C00, 64'hFFFFFFFF3F800000, 4'h0},
  {2'd2, 2'd1, 3'd0, 64'hFFFFFFFFFFFFC100, 64'hC004000000000000, 4'h0},
  {2'd0, 2'd1, 3'd0, 64'hFFFFFFFF3FC00000, 64'h3FF8000000000000, 4'h0},
  {2'd2, 2'd0, 3'd0, 64'hFFFFFFFFFFFF8000, 64'hFFFFFFFF80000000, 4'h0},
  {2'd0, 2'd1, 3'd0, 64'hFFFFFFFF7F800000, 64'h7FF0000000000000, 4'h0},
  {2'd2, 2'd1, 3'd0, 64'hFFFFFFFFFFFFFC00, 64'hFFF0000000000000, 4'h0},
  // Double to single, 1 + 0.75 ulp and the 0.5 ulp tie
  {2'd1, 2'd0, 3'd0, 64'h3FF0000018000000, 64'hFFFFFFFF3F800001, 4'h1},
  {2'd1, 2'd0, 3'd1, 64'h3FF0000018000000, 64'hFFFFFFFF3F800000, 4'h1},
  {2'd1, 2'd0, 3'd0, 64'h3FF0000010000000, 64'hFFFFFFFF3F800000, 4'h1},
  {2'd1, 2'd0, 3'd4, 64'h3FF0000010000000, 64'hFFFFFFFF3F800001, 4'h1},
  {2'd1, 2'd0, 3'd2, 64'hBFF0000018000000, 64'hFFFFFFFFBF800001, 4'h1},
  {2'd1, 2'd0, 3'd3, 64'hBFF0000018000000, 64'hFFFFFFFFBF800000, 4'h1},
  // Single to half, 0.25 ulp up, odd tie, carry into the next binade
  {2'd0, 2'd2, 3'd3, 64'hFFFFFFFF3F800800, 64'hFFFFFFFFFFFF3C01, 4'h1},
  {2'd0, 2'd2, 3'd0, 64'hFFFFFFFFBF803000, 64'hFFFFFFFFFFFFBC02, 4'h1},
  {2'd0, 2'd2, 3'd1, 64'hFFFFFFFFBF803000, 64'hFFFFFFFFFFFFBC01, 4'h1},
  {2'd0, 2'd2, 3'd3, 64'hFFFFFFFF3FFFFFFF, 64'hFFFFFFFFFFFF4000, 4'h1},
  // 2^20 into half overflows, inf or max finite per mode
  {2'd1, 2'd2, 3'd0, 64'h4130000000000000, 64'hFFFFFFFFFFFF7C00, 4'h5},
  {2'd1, 2'd2, 3'd1, 64'h4130000000000000, 64'hFFFFFFFFFFFF7BFF, 4'h5},
  {2'd1, 2'd2, 3'd3, 64'hC130000000000000, 64'hFFFFFFFFFFFFFBFF, 4'h5},
  {2'd1, 2'd2, 3'd2, 64'hC130000000000000, 64'hFFFFFFFFFFFFFC00, 4'h5},
  // Tiny values into half, subnormal or zero
  {2'd0, 2'd2, 3'd0, 64'hFFFFFFFF35800001, 64'hFFFFFFFFFFFF0010, 4'h3},
  {2'd1, 2'd2, 3'd1, 64'h39B0000000000000, 64'hFFFFFFFFFFFF0000, 4'h3},
  {2'd1, 2'd2, 3'd3, 64'h39B0000000000000, 64'hFFFFFFFFFFFF0001, 4'h3},
  // Half subnormals widen exactly
  {2'd2, 2'd0, 3'd0, 64'hFFFFFFFFFFFF0001, 64'hFFFFFFFF33800000, 4'h0},
  {2'd2, 2'd1, 3'd0, 64'hFFFFFFFFFFFF8200, 64'hBF00000000000000, 4'h0},
  // NaNs, the last one a single with broken boxing
  {2'd0, 2'd1, 3'd0, 64'hFFFFFFFF7F800001, 64'h7FF8000000000000, 4'h8},
  {2'd1, 2'd0, 3'd0, 64'h7FF8000000000123, 64'hFFFFFFFF7FC00000, 4'h0},
  {2'd2, 2'd0, 3'd0, 64'hFFFFFFFFFFFF7C01, 64'hFFFFFFFF7FC00000, 4'h8},
  {2'd0, 2'd1, 3'd0, 64'h000000003F800000, 64'h7FF8000000000000, 4'h0}
};

/* dv/fpCvtTb.sv */
/*
  Testbench for the fcvt converter top level.
  Applies the vector table twice, first with random idle gaps and then
  back to back, and checks result, flags and the two-cycle latency of
  every outValid against queued expectations.
*/

`timescale 1ns/1ns

module fpCvtTb;

  localparam int ClkPeriod = 8;

  // One table row
  typedef struct packed {
    logic [1:0]  srcFmt;
    logic [1:0]  dstFmt;
    logic [2:0]  rm;
    logic [63:0] operand;
    logic [63:0] expResult;
    logic [3:0]  expFlags;
  } vecRowT;

  `include "fpCvtVectors.svh"

  // Each row takes at most 3 cycles with gaps plus 1 back to back
  localparam int WatchdogCycles = NumRows * 4 + 100;

  logic             clk;
  logic             rstN;
  logic             inValid;
  fpFmtPkg::fmtT    srcFmt;
  fpFmtPkg::fmtT    dstFmt;
  fpFmtPkg::rmT     rm;
  fpFmtPkg::fpWordT operand;
  logic             outValid;
  fpFmtPkg::fpWordT result;
  fpFmtPkg::flagsT  flags;

  // Pending expectations with the oldest first
  logic [63:0] expResQ [$];
  logic [3:0]  expFlagsQ [$];
  int          issueQ [$];
  int          rowQ [$];

  int cycleCnt = 0;
  int errCnt   = 0;
  int checkCnt = 0;

  fpCvt #(.NumFmts(3)) i_fpCvt (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .srcFmt   (srcFmt),
    .dstFmt   (dstFmt),
    .rm       (rm),
    .operand  (operand),
    .outValid (outValid),
    .result   (result),
    .flags    (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] expected);
    checkCnt++;
    if (got !== expected) begin
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
      errCnt++;
    end
  endtask

  // Outputs settle on the rising edge and are looked at half a cycle later
  always @(negedge clk) begin
    int row;
    if (rstN && outValid) begin
      if (expResQ.size() == 0) begin
        $display("Error at %0t: outValid high with no conversion pending", $time);
        errCnt++;
      end else begin
        row = rowQ.pop_front();
        checkValue($sformatf("result row %0d", row), result, expResQ.pop_front());
        checkValue($sformatf("flags row %0d", row), 64'(flags), 64'(expFlagsQ.pop_front()));
        // Cycles from the input cycle to the output cycle
        checkValue($sformatf("latency row %0d", row), 64'(cycleCnt - issueQ.pop_front()),
                   64'd2);
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Called 1 ns after a rising edge and returns 1 ns after the next one
  task automatic applyRow(input int idx);
    vecRowT row;
    row     = vecTable[idx];
    inValid = 1'b1;
    srcFmt  = row.srcFmt;
    dstFmt  = row.dstFmt;
    rm      = fpFmtPkg::rmT'(row.rm);
    operand = row.operand;
    expResQ.push_back(row.expResult);
    expFlagsQ.push_back(row.expFlags);
    issueQ.push_back(cycleCnt);
    rowQ.push_back(idx);
    @(posedge clk);
    #1;
  endtask

  task automatic idleCycles(input int n);
    inValid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    int unsigned gap;
    void'($urandom(77));
    rstN    = 1'b0;
    inValid = 1'b0;
    srcFmt  = fpFmtPkg::fmtSingle;
    dstFmt  = fpFmtPkg::fmtSingle;
    rm      = fpFmtPkg::rne;
    operand = '0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    // Quiet period where outValid must stay low
    idleCycles(3);

    // Pass one with random idle cycles between rows
    for (int i = 0; i < NumRows; i++) begin
      gap = $urandom % 3;
      idleCycles(int'(gap));
      applyRow(i);
    end

    // Pass two with a new row every cycle
    for (int i = 0; i < NumRows; i++) begin
      applyRow(i);
    end
    inValid = 1'b0;

    while (expResQ.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);

    $display("Summary: %0d rows applied, %0d checks, %0d errors",
             2 * NumRows, checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: results still pending after %0d cycles, %0d outstanding",
             WatchdogCycles, expResQ.size());
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+dv
verilog/fpFmtPkg.sv
verilog/fpCvtIf.sv
verilog/fmtParams.sv
verilog/fpUnpack.sv
verilog/fpRound.sv
verilog/fpCvt.sv
dv/fpCvtTb.sv

/* run.sh */
#!/bin/sh
# Build the converter testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module fpCvtTb \
  -Mdir obj_dir -o fpCvtSim -f src.f \
  && ./obj_dir/fpCvtSim > sim.log 2>&1

grep -q "TESTBENCH PASSED" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed, see sim.log"; exit 1; }
